// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -f vlog.f --top-module tb_smu_ctrl -o tb_smu_ctrl
	./obj_dir/tb_smu_ctrl > sim.log 2>&1 || true
	cat sim.log
	! grep -q ">>> FAIL" sim.log
	grep -q ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: ctrl_reg_file.sv
//////////////////////////////
// control register file
// applies set/clear/toggle writes and soft reset, serves readback
//////////////////////////////
`default_nettype none

module ctrl_reg_file
  import smu_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  spi_frame_t        frame,
  input  logic              frame_valid,
  input  logic [byte_w-1:0] rd_addr,
  input  nib_t              mon_rails,
  output logic [byte_w-1:0] rd_data,
  output ctrl_regs_t        regs
);

  ctrl_regs_t regs_q;

  //////////////////////////////
  // write decode

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      regs_q <= ctrl_regs_default;
    else if (frame_valid)
    begin
      case (frame.addr)
        addr_led:
          regs_q.led <= reg_update(regs_q.led, frame.value);
        // peripheral select, see spi_periph_route
        addr_mux:
          regs_q.mux <= reg_update(regs_q.mux, frame.value);
        addr_dac:
          regs_q.dac <= reg_update(regs_q.dac, frame.value);
        addr_rails:
          regs_q.rails <= reg_update(regs_q.rails, frame.value);
        // value byte is ignored here
        addr_soft_reset:
          regs_q <= ctrl_regs_default;
        addr_dac_ref_mux:
          regs_q.dac_ref_mux <= reg_update(regs_q.dac_ref_mux, frame.value);
        addr_adc:
          regs_q.adc <= reg_update(regs_q.adc, frame.value);
        // clamp switches are active low
        addr_clamp1:
          regs_q.clamp1 <= reg_update(regs_q.clamp1, frame.value);
        addr_clamp2:
          regs_q.clamp2 <= reg_update(regs_q.clamp2, frame.value);
        addr_relay_com:
          regs_q.relay_com <= reg_update(regs_q.relay_com, frame.value);
        addr_irange_x_sw:
          regs_q.irange_x_sw <= reg_update(regs_q.irange_x_sw, frame.value);
        addr_rails_oe:
          regs_q.rails_oe <= reg_update(regs_q.rails_oe, frame.value);
        // instrumentation amp feedback switches
        addr_ina_vfb_sw:
          regs_q.ina_vfb_sw <= reg_update(regs_q.ina_vfb_sw, frame.value);
        addr_ina_ifb_sw:
          regs_q.ina_ifb_sw <= reg_update(regs_q.ina_ifb_sw, frame.value);
        addr_ina_vfb_atten_sw:
          regs_q.ina_vfb_atten_sw <= reg_update(regs_q.ina_vfb_atten_sw, frame.value);
        addr_isense_mux:
          regs_q.isense_mux <= reg_update(regs_q.isense_mux, frame.value);
        // output and sense relays
        addr_relay_out:
          regs_q.relay_out <= reg_update(regs_q.relay_out, frame.value);
        addr_relay_vsense:
          regs_q.relay_vsense <= reg_update(regs_q.relay_vsense, frame.value);
        addr_irange_yz_sw:
          regs_q.irange_yz_sw <= reg_update(regs_q.irange_yz_sw, frame.value);
        // mon_rails and unmapped addresses drop the write
        default:
          regs_q <= regs_q;
      endcase
    end
  end

  assign regs = regs_q;

  //////////////////////////////
  // readback

  // zero extend the nibble, unmapped reads give zero
  always_comb
  begin
    rd_data = '0;
    case (rd_addr)
      addr_led:
        rd_data = {{(byte_w - nib_w){1'b0}}, regs_q.led};
      addr_mon_rails:
        rd_data = {{(byte_w - nib_w){1'b0}}, mon_rails};
      default:
        rd_data = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: smu_ctrl_top.sv
//////////////////////////////
// smu control fpga top
// spi register bank plus peripheral spi routing
//////////////////////////////
`default_nettype none

module smu_ctrl_top
  import smu_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  // host spi
  input  logic                sclk,
  input  logic                cs_n,
  input  logic                cs2_n,
  input  logic                mosi,
  output logic                miso,
  // board side
  input  nib_t                mon_rails,
  output ctrl_regs_t          regs,
  output logic [n_periph-1:0] periph_cs_n,
  input  logic [n_periph-1:0] periph_miso
);

  spi_frame_t        frame;
  logic              frame_valid;
  logic [byte_w-1:0] rd_addr;
  logic [byte_w-1:0] rd_data;
  logic              bank_miso;

  // frame receiver on cs_n
  spi_frame_rx rx_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .rd_data     (rd_data),
    .frame       (frame),
    .frame_valid (frame_valid),
    .rd_addr     (rd_addr),
    .bank_miso   (bank_miso)
  );

  ctrl_reg_file regs_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame       (frame),
    .frame_valid (frame_valid),
    .rd_addr     (rd_addr),
    .mon_rails   (mon_rails),
    .rd_data     (rd_data),
    .regs        (regs)
  );

  // cs2_n steers the bus to the peripherals
  spi_periph_route route_i (
    .cs2_n       (cs2_n),
    .mux_sel     (regs.mux),
    .bank_miso   (bank_miso),
    .periph_miso (periph_miso),
    .periph_cs_n (periph_cs_n),
    .miso        (miso)
  );

endmodule

`default_nettype wire

// File: smu_pkg.sv
//////////////////////////////
// smu control bank definitions
// widths, register map, safe defaults and the set/clear/toggle rule
//////////////////////////////
`default_nettype none

package smu_pkg;

  //////////////////////////////
  // widths
  localparam int nib_w      = 4;
  localparam int frame_bits = 16;
  localparam int byte_w     = 8;
  localparam int n_periph   = 4;
  // bit counter also has to see frames longer than 16
  localparam int cnt_w      = $clog2(frame_bits + 1);

  //////////////////////////////
  // register map
  localparam logic [byte_w-1:0] addr_led              = 8'd7;
  localparam logic [byte_w-1:0] addr_mux              = 8'd8;
  localparam logic [byte_w-1:0] addr_dac              = 8'd9;
  localparam logic [byte_w-1:0] addr_rails            = 8'd10;
  localparam logic [byte_w-1:0] addr_soft_reset       = 8'd11;
  localparam logic [byte_w-1:0] addr_dac_ref_mux      = 8'd12;
  localparam logic [byte_w-1:0] addr_adc              = 8'd14;
  localparam logic [byte_w-1:0] addr_clamp1           = 8'd15;
  localparam logic [byte_w-1:0] addr_clamp2           = 8'd16;
  localparam logic [byte_w-1:0] addr_relay_com        = 8'd17;
  localparam logic [byte_w-1:0] addr_irange_x_sw      = 8'd18;
  // read only, rail monitor inputs
  localparam logic [byte_w-1:0] addr_mon_rails        = 8'd19;
  localparam logic [byte_w-1:0] addr_rails_oe         = 8'd24;
  localparam logic [byte_w-1:0] addr_ina_vfb_sw       = 8'd25;
  localparam logic [byte_w-1:0] addr_ina_ifb_sw       = 8'd28;
  localparam logic [byte_w-1:0] addr_ina_vfb_atten_sw = 8'd29;
  localparam logic [byte_w-1:0] addr_isense_mux       = 8'd30;
  localparam logic [byte_w-1:0] addr_relay_out        = 8'd31;
  localparam logic [byte_w-1:0] addr_relay_vsense     = 8'd32;
  localparam logic [byte_w-1:0] addr_irange_yz_sw     = 8'd33;

  // shifted out while the address byte comes in
  localparam logic [byte_w-1:0] rd_idle_byte = 8'hFF;

  //////////////////////////////
  // types
  typedef logic [nib_w-1:0] nib_t;

  // one field per writable register, led first
  typedef struct packed {
    nib_t led;
    nib_t mux;
    nib_t dac;
    nib_t rails;
    nib_t dac_ref_mux;
    nib_t adc;
    nib_t clamp1;
    nib_t clamp2;
    nib_t relay_com;
    nib_t irange_x_sw;
    nib_t rails_oe;
    nib_t ina_vfb_sw;
    nib_t ina_ifb_sw;
    nib_t ina_vfb_atten_sw;
    nib_t isense_mux;
    nib_t relay_out;
    nib_t relay_vsense;
    nib_t irange_yz_sw;
  } ctrl_regs_t;

  // address byte goes first on the wire
  typedef struct packed {
    logic [byte_w-1:0] addr;
    logic [byte_w-1:0] value;
  } spi_frame_t;

  // safe state, active low switches held off
  localparam ctrl_regs_t ctrl_regs_default = '{
    led:              4'b0000,
    mux:              4'b0000,
    dac:              4'b0000,
    rails:            4'b0000,
    dac_ref_mux:      4'b1111,
    adc:              4'b0000,
    clamp1:           4'b1111,
    clamp2:           4'b1111,
    relay_com:        4'b0000,
    irange_x_sw:      4'b0000,
    // rails output enable is active low, keep rails off
    rails_oe:         4'b0001,
    ina_vfb_sw:       4'b0000,
    ina_ifb_sw:       4'b1111,
    ina_vfb_atten_sw: 4'b1111,
    isense_mux:       4'b1111,
    relay_out:        4'b0000,
    relay_vsense:     4'b0000,
    irange_yz_sw:     4'b0000
  };

  // low nibble sets, high nibble clears, bits in both toggle
  function automatic nib_t reg_update(input nib_t cur, input logic [byte_w-1:0] value);
    nib_t set_b;
    nib_t clr_b;
    nib_t tog_b;
    set_b = value[nib_w-1:0];
    clr_b = value[byte_w-1:nib_w];
    tog_b = set_b & clr_b;
    // set first, then clear, then flip the overlap
    return ((cur | (set_b & ~tog_b)) & ~(clr_b & ~tog_b)) ^ tog_b;
  endfunction

endpackage

`default_nettype wire

// File: spi_frame_rx.sv
//////////////////////////////
// spi frame receiver
// samples the spi pins in the clk domain, assembles 16-bit frames
// and shifts readback data out on miso
//////////////////////////////
`default_nettype none

module spi_frame_rx
  import smu_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              sclk,
  input  logic              cs_n,
  input  logic              mosi,
  input  logic [byte_w-1:0] rd_data,
  output spi_frame_t        frame,
  output logic              frame_valid,
  output logic [byte_w-1:0] rd_addr,
  output logic              bank_miso
);

  // sync chains, bit 2 is the previous synced value
  logic [2:0]            sclk_q;
  logic [2:0]            cs_n_q;
  logic [1:0]            mosi_q;

  logic                  sclk_rise;
  logic                  sclk_fall;
  logic                  cs_rise;
  logic                  cs_fall;
  logic                  cs_act;
  logic                  load_rd;

  logic [cnt_w-1:0]      bit_cnt;
  logic [frame_bits-1:0] shift_q;
  // bits still to go out after the current miso bit
  logic [byte_w-1:0]     tx_q;

  //////////////////////////////
  // pin synchronizers

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      sclk_q <= '0;
      // bank idles deselected
      cs_n_q <= '1;
    end
    else
    begin
      sclk_q <= {sclk_q[1:0], sclk};
      cs_n_q <= {cs_n_q[1:0], cs_n};
    end
  end

  // same depth as sclk so data lines up with the rise
  always_ff @(posedge clk)
  begin
    mosi_q <= {mosi_q[0], mosi};
  end

  assign sclk_rise = sclk_q[1] & ~sclk_q[2];
  assign sclk_fall = ~sclk_q[1] & sclk_q[2];
  assign cs_rise   = cs_n_q[1] & ~cs_n_q[2];
  assign cs_fall   = ~cs_n_q[1] & cs_n_q[2];
  assign cs_act    = ~cs_n_q[1];

  // first fall after the address byte picks up the readback
  assign load_rd = cs_act && sclk_fall && (bit_cnt == cnt_w'(byte_w));

  //////////////////////////////
  // receive side

  // count saturates so long frames stay invalid
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      bit_cnt <= '0;
    else if (cs_fall)
      bit_cnt <= '0;
    else if (cs_act && sclk_rise && (bit_cnt != '1))
      bit_cnt <= bit_cnt + 1'b1;
  end

  // msb first, new bit into the lsb
  always_ff @(posedge clk)
  begin
    if (cs_act && sclk_rise)
      shift_q <= {shift_q[frame_bits-2:0], mosi_q[1]};
  end

  // only exact 16-bit frames get written
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      frame_valid <= 1'b0;
    else
      frame_valid <= cs_rise && (bit_cnt == cnt_w'(frame_bits));
  end

  assign frame = shift_q;
  // low byte holds the address once 8 bits are in
  assign rd_addr = shift_q[byte_w-1:0];

  //////////////////////////////
  // readback side

  // mode 0, launched on fall and sampled by the host on the next rise
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      bank_miso <= 1'b1;
    else if (cs_fall)
      bank_miso <= rd_idle_byte[byte_w-1];
    else if (cs_rise)
      bank_miso <= 1'b1;
    else if (load_rd)
      bank_miso <= rd_data[byte_w-1];
    else if (cs_act && sclk_fall)
      bank_miso <= tx_q[byte_w-1];
  end

  always_ff @(posedge clk)
  begin
    if (cs_fall)
      tx_q <= {rd_idle_byte[byte_w-2:0], 1'b0};
    else if (load_rd)
      tx_q <= {rd_data[byte_w-2:0], 1'b0};
    else if (cs_act && sclk_fall)
      tx_q <= {tx_q[byte_w-2:0], 1'b0};
  end

endmodule

`default_nettype wire

// File: spi_periph_route.sv
//////////////////////////////
// peripheral spi router
// chip selects and miso source from cs2_n and the mux register
//////////////////////////////
`default_nettype none

module spi_periph_route
  import smu_pkg::*;
(
  input  logic                cs2_n,
  input  nib_t                mux_sel,
  input  logic                bank_miso,
  input  logic [n_periph-1:0] periph_miso,
  output logic [n_periph-1:0] periph_cs_n,
  output logic                miso
);

  // bit 0 adc03, 1 dac, 2 config flash, 3 adc02
  logic [n_periph-1:0] sel;

  assign sel = mux_sel[n_periph-1:0];

  always_comb
  begin
    if (cs2_n)
    begin
      // nothing selected, bank answers on miso
      periph_cs_n = '1;
      miso        = bank_miso;
    end
    else
    begin
      // selects are active low
      periph_cs_n = ~sel;
      // unselected parts may float, mask them out
      miso        = |(sel & periph_miso);
    end
  end

endmodule

`default_nettype wire

// File: tb_smu_ctrl.sv
//////////////////////////////
// smu control bank testbench
// directed spi frames against a bit-level model of the bank
//////////////////////////////
`default_nettype none

module tb_smu_ctrl
  import smu_pkg::*;
;

  typedef logic [$bits(ctrl_regs_t)-1:0] chk_t;

  logic                clk = 1'b0;
  logic                rst_n;
  logic                sclk;
  logic                cs_n;
  logic                cs2_n;
  logic                mosi;
  logic                miso;
  nib_t                mon_rails;
  ctrl_regs_t          regs;
  logic [n_periph-1:0] periph_cs_n;
  logic [n_periph-1:0] periph_miso;

  // expected register state
  ctrl_regs_t          model;
  logic [7:0]          wr_addrs [18];

  always #10 clk = ~clk;

  smu_ctrl_top dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .cs2_n       (cs2_n),
    .mosi        (mosi),
    .miso        (miso),
    .mon_rails   (mon_rails),
    .regs        (regs),
    .periph_cs_n (periph_cs_n),
    .periph_miso (periph_miso)
  );

  //////////////////////////////
  // model

  function automatic ctrl_regs_t safe_defaults();
    ctrl_regs_t d;
    d = '0;
    d.dac_ref_mux      = 4'b1111;
    d.clamp1           = 4'b1111;
    d.clamp2           = 4'b1111;
    d.ina_ifb_sw       = 4'b1111;
    d.ina_vfb_atten_sw = 4'b1111;
    d.isense_mux       = 4'b1111;
    d.rails_oe         = 4'b0001;
    return d;
  endfunction

  // a bit named in both nibbles flips and clear beats set otherwise
  function automatic nib_t next_nib(input nib_t cur, input logic [7:0] v);
    nib_t n;
    n = cur;
    for (int i = 0; i < 4; i++)
    begin
      if (v[i] && v[i+4])
        n[i] = ~cur[i];
      else if (v[i+4])
        n[i] = 1'b0;
      else if (v[i])
        n[i] = 1'b1;
    end
    return n;
  endfunction

  function automatic ctrl_regs_t model_write(input ctrl_regs_t m, input logic [7:0] a,
                                             input logic [7:0] v);
    ctrl_regs_t r;
    r = m;
    case (a)
      8'd7:  r.led              = next_nib(m.led, v);
      8'd8:  r.mux              = next_nib(m.mux, v);
      8'd9:  r.dac              = next_nib(m.dac, v);
      8'd10: r.rails            = next_nib(m.rails, v);
      8'd11: r                  = safe_defaults();
      8'd12: r.dac_ref_mux      = next_nib(m.dac_ref_mux, v);
      8'd14: r.adc              = next_nib(m.adc, v);
      8'd15: r.clamp1           = next_nib(m.clamp1, v);
      8'd16: r.clamp2           = next_nib(m.clamp2, v);
      8'd17: r.relay_com        = next_nib(m.relay_com, v);
      8'd18: r.irange_x_sw      = next_nib(m.irange_x_sw, v);
      8'd24: r.rails_oe         = next_nib(m.rails_oe, v);
      8'd25: r.ina_vfb_sw       = next_nib(m.ina_vfb_sw, v);
      8'd28: r.ina_ifb_sw       = next_nib(m.ina_ifb_sw, v);
      8'd29: r.ina_vfb_atten_sw = next_nib(m.ina_vfb_atten_sw, v);
      8'd30: r.isense_mux       = next_nib(m.isense_mux, v);
      8'd31: r.relay_out        = next_nib(m.relay_out, v);
      8'd32: r.relay_vsense     = next_nib(m.relay_vsense, v);
      8'd33: r.irange_yz_sw     = next_nib(m.irange_yz_sw, v);
      default: r = m;
    endcase
    return r;
  endfunction

  //////////////////////////////
  // drivers and checks

  task automatic check_eq(input string test_name, input chk_t expected, input chk_t actual);
    assert (actual === expected)
    else
    begin
      $display("MISMATCH %s expected %h actual %h", test_name, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  // mode 0 msb first with nbits taken from the top of data
  task automatic spi_xfer(input logic [15:0] data, input int nbits,
                          output logic [15:0] rx_bits);
    rx_bits = '0;
    @(posedge clk);
    sclk <= 1'b0;
    cs_n <= 1'b0;
    for (int i = 0; i < nbits; i++)
    begin
      @(posedge clk);
      mosi <= data[15-i];
      repeat (2) @(posedge clk);
      // miso is settled half a cycle before the rise
      @(negedge clk);
      rx_bits = {rx_bits[14:0], miso};
      @(posedge clk);
      sclk <= 1'b1;
      repeat (4) @(posedge clk);
      sclk <= 1'b0;
    end
    repeat (4) @(posedge clk);
    cs_n <= 1'b1;
    // write lands within 4 cycles of the rise
    repeat (8) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic write_check(input string test_name, input logic [7:0] a,
                             input logic [7:0] v);
    logic [15:0] rx;
    spi_xfer({a, v}, 16, rx);
    model = model_write(model, a, v);
    check_eq(test_name, chk_t'(model), chk_t'(regs));
  endtask

  // value byte of zero leaves the register alone
  task automatic read_check(input string test_name, input logic [7:0] a,
                            input logic [7:0] exp_byte);
    logic [15:0] rx;
    spi_xfer({a, 8'h00}, 16, rx);
    check_eq(test_name, chk_t'({8'hFF, exp_byte}), chk_t'(rx));
    check_eq(test_name, chk_t'(model), chk_t'(regs));
  endtask

  //////////////////////////////
  // tests

  task automatic test_reset_defaults();
    check_eq("reset_defaults", chk_t'(safe_defaults()), chk_t'(regs));
    check_eq("reset_defaults", chk_t'(4'hF), chk_t'(periph_cs_n));
  endtask

  task automatic test_set_clear_toggle();
    logic [7:0] v;
    for (int r = 0; r < 3; r++)
    begin
      for (int i = 0; i < 18; i++)
      begin
        v = 8'($urandom);
        // middle round uses equal nibbles for a pure toggle
        if (r == 1)
          v = {v[3:0], v[3:0]};
        write_check("set_clear_toggle", wr_addrs[i], v);
      end
    end
  endtask

  task automatic test_soft_reset();
    logic [15:0] rx;
    for (int i = 0; i < 18; i++)
      write_check("soft_reset", wr_addrs[i], 8'($urandom));
    // low nibble zero so the short frame below lines up as a led write
    write_check("soft_reset", 8'd11, {4'($urandom), 4'h0});
    // taken as a frame these 12 bits would write 0x0F to the led
    spi_xfer(16'h70F0, 12, rx);
    check_eq("short_frame", chk_t'(model), chk_t'(regs));
    // toggles every bit of any register it might hit
    write_check("unmapped_write", 8'd13, 8'hFF);
  endtask

  task automatic test_readback();
    write_check("readback", 8'd7, 8'h0B);
    read_check("readback_led", 8'd7, {4'h0, model.led});
    @(posedge clk);
    mon_rails <= 4'hA;
    read_check("readback_mon_rails", 8'd19, 8'h0A);
    read_check("readback_unmapped", 8'd20, 8'h00);
  endtask

  task automatic route_sweep();
    logic                exp_miso;
    logic [n_periph-1:0] exp_cs;
    exp_cs = ~model.mux;
    for (int pm = 0; pm < 16; pm++)
    begin
      @(posedge clk);
      cs2_n       <= 1'b0;
      periph_miso <= 4'(pm);
      @(negedge clk);
      exp_miso = 1'b0;
      for (int i = 0; i < n_periph; i++)
        if (model.mux[i] && periph_miso[i])
          exp_miso = 1'b1;
      check_eq("routing_cs", chk_t'(exp_cs), chk_t'(periph_cs_n));
      check_eq("routing_miso", chk_t'(exp_miso), chk_t'(miso));
    end
    @(posedge clk);
    cs2_n       <= 1'b1;
    // quiet peripherals so only the bank can hold miso high
    periph_miso <= '0;
    @(negedge clk);
    // bank idles high between frames
    check_eq("routing_idle_cs", chk_t'(4'hF), chk_t'(periph_cs_n));
    check_eq("routing_idle_miso", chk_t'(1'b1), chk_t'(miso));
  endtask

  task automatic test_routing();
    write_check("routing", 8'd8, 8'h05);
    route_sweep();
    write_check("routing", 8'd8, 8'h66);
    route_sweep();
  endtask

  //////////////////////////////
  // main sequence and watchdog

  initial
  begin
    rst_n       = 1'b0;
    sclk        = 1'b0;
    cs_n        = 1'b1;
    cs2_n       = 1'b1;
    mosi        = 1'b0;
    mon_rails   = 4'h0;
    periph_miso = 4'h0;
    wr_addrs = '{8'd7, 8'd8, 8'd9, 8'd10, 8'd12, 8'd14, 8'd15, 8'd16, 8'd17,
                 8'd18, 8'd24, 8'd25, 8'd28, 8'd29, 8'd30, 8'd31, 8'd32, 8'd33};
    void'($urandom(32'had26));
    model = safe_defaults();
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    test_reset_defaults();
    test_set_clear_toggle();
    test_soft_reset();
    test_readback();
    test_routing();
    $display(">>> PASS");
    $finish;
  end

  // about 145 cycles per frame plus short routing sweeps
  initial
  begin : watchdog
    int n_frames;
    int limit;
    n_frames = 3 * 18 + 18 + 3 + 4 + 2;
    limit    = n_frames * 200 + 1000;
    repeat (limit) @(posedge clk);
    $display("timeout, tests did not finish within %0d cycles", limit);
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// File: vlog.f
smu_pkg.sv
spi_frame_rx.sv
ctrl_reg_file.sv
spi_periph_route.sv
smu_ctrl_top.sv
tb_smu_ctrl.sv
